/* list.f */
+incdir+test
source/vec_alu_pkg.sv
source/vadd_unit_block.sv
source/vadd_result_pack.sv
source/vadd_exec.sv
source/axil_vadd_regs.sv
source/vadd_top.sv
test/tb_vadd_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_vadd_top
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS = $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/tb_vadd_tasks.svh */
task automatic check_word(input logic [AXI_DATA_W-1:0] got, exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		err_count++;
	end
endtask

task automatic check_data(input logic [VLEN_BITS-1:0] got, exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		err_count++;
	end
endtask

task automatic check_flags(input logic [FLAG_W-1:0] got, exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		err_count++;
	end
endtask

task automatic check_resp(input logic [1:0] got, exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		err_count++;
	end
endtask

task automatic protocol_fault(input string what);
	$display("at %0t: %s", $time, what);
	err_count++;
endtask

task automatic note_result(input string name, input int errs_before);
	if (err_count == errs_before) begin
		tests_ok++;
		$display("test %s: ok", name);
	end else begin
		tests_bad++;
		$display("test %s: FAILED with %0d errors", name, err_count - errs_before);
	end
endtask

// valids dropped a short delay after the handshake edge
task automatic aw_accept();
	@(negedge clk);
	while (!awready && !wready) @(negedge clk);
	if (awready !== wready)
		protocol_fault("awready and wready did not rise together");
	@(posedge clk);
	#1;
	awvalid = 1'b0;
	wvalid  = 1'b0;
endtask

task automatic take_write_resp();
	bready = 1'b1;
	@(negedge clk);
	while (!bvalid) @(negedge clk);
	check_resp(bresp, 2'b00, "write response");
	@(posedge clk);
	#1;
	bready = 1'b0;
endtask

task automatic ar_accept();
	@(negedge clk);
	while (!arready) @(negedge clk);
	@(posedge clk);
	#1;
	arvalid = 1'b0;
endtask

task automatic take_read_data(output logic [AXI_DATA_W-1:0] data);
	rready = 1'b1;
	@(negedge clk);
	while (!rvalid) @(negedge clk);
	data = rdata;
	check_resp(rresp, 2'b00, "read response");
	@(posedge clk);
	#1;
	rready = 1'b0;
endtask

task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
	awaddr  = addr;
	wdata   = data;
	wstrb   = '1;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	aw_accept();
	take_write_resp();
endtask

task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
	araddr  = addr;
	arvalid = 1'b1;
	ar_accept();
	take_read_data(data);
endtask

// element by element, modulo 2**sew, flag in the element's top byte
function automatic void expected_result(
	input  logic [VLEN_BITS-1:0] a, b,
	input  logic [SEW_W-1:0]     sew,
	input  logic [OPSEL_W-1:0]   op,
	output logic [VLEN_BITS-1:0] res,
	output logic [FLAG_W-1:0]    flags
);
	int               ebits;
	logic [VLEN_BITS:0] mask;
	logic [VLEN_BITS:0] x;
	logic [VLEN_BITS:0] y;
	logic [VLEN_BITS:0] s;
	ebits = 8 << sew;
	mask  = {1'b0, {VLEN_BITS{1'b1}}} >> (VLEN_BITS - ebits);
	res   = '0;
	flags = '0;
	for (int e = 0; e < VLEN_BITS / ebits; e++) begin
		x = ({1'b0, a} >> (e * ebits)) & mask;
		y = ({1'b0, b} >> (e * ebits)) & mask;
		if (op == OP_VRSUB)
			{x, y} = {y, x};
		if (op == OP_VADD) begin
			s = x + y;
			flags[(e + 1) * ebits / 8 - 1] = s[ebits];
		end else begin
			s = x - y;
			flags[(e + 1) * ebits / 8 - 1] = (x < y);  // borrow
		end
		res = res | ((s[VLEN_BITS-1:0] & mask[VLEN_BITS-1:0]) << (e * ebits));
	end
endfunction

task automatic exec_and_check(input logic [VLEN_BITS-1:0] a, b,
		input logic [SEW_W-1:0] sew, input logic [OPSEL_W-1:0] op);
	logic [AXI_DATA_W-1:0] lo;
	logic [AXI_DATA_W-1:0] hi;
	logic [AXI_DATA_W-1:0] st;
	logic [VLEN_BITS-1:0]  exp_res;
	logic [FLAG_W-1:0]     exp_flags;
	axil_write(REG_VEC0_LO, a[31:0]);
	axil_write(REG_VEC0_HI, a[63:32]);
	axil_write(REG_VEC1_LO, b[31:0]);
	axil_write(REG_VEC1_HI, b[63:32]);
	axil_write(REG_CTRL, {1'b1, 23'd0, op, sew});
	st = '0;
	while (!st[0])
		axil_read(REG_STATUS, st);
	axil_read(REG_RES_LO, lo);
	axil_read(REG_RES_HI, hi);
	expected_result(a, b, sew, op, exp_res, exp_flags);
	check_data({hi, lo}, exp_res, $sformatf("sew %0d op %0d result", sew, op));
	check_flags(st[STAT_FLAGS +: FLAG_W], exp_flags, $sformatf("sew %0d op %0d flags", sew, op));
endtask

task automatic test_reset_state();
	int                    errs;
	logic [AXI_DATA_W-1:0] rd;
	errs = err_count;
	for (int pass = 0; pass < 2; pass++) begin
		for (int i = 0; i < 8; i++) begin
			axil_read(AXI_ADDR_W'(4 * i), rd);
			check_word(rd, '0, "register after reset");
		end
		axil_read(5'h13, rd);
		check_word(rd, '0, "unmapped address");
		if (pass == 0)
			axil_write(5'h13, 32'hffff_ffff);  // must not land anywhere
	end
	note_result("reset state", errs);
endtask

task automatic test_e8_wrap();
	int errs;
	errs = err_count;
	exec_and_check(64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101, SEW_E8, OP_VADD);
	note_result("sew8 add wrap", errs);
endtask

task automatic test_sub_borrow();
	int errs;
	errs = err_count;
	exec_and_check(64'h0005_8000_0100_0001, 64'h0003_8001_0001_0002, SEW_E16, OP_VSUB);
	exec_and_check(64'h0000_0001_ffff_0000, 64'h0000_0100_0000_0001, SEW_E32, OP_VSUB);
	note_result("sew16/32 sub borrow", errs);
endtask

task automatic test_e64_ops();
	int errs;
	errs = err_count;
	exec_and_check(64'h0000_0000_0000_0001, 64'h1000_0000_0000_0000, SEW_E64, OP_VRSUB);
	exec_and_check(64'h0000_0000_0000_0005, 64'h0000_0000_0000_0003, SEW_E64, OP_VRSUB);
	exec_and_check(64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001, SEW_E64, OP_VADD);
	note_result("sew64 rsub and ripple add", errs);
endtask

task automatic test_random_ops(input int n);
	int                   errs;
	logic [31:0]          r;
	logic [OPSEL_W-1:0]   op;
	logic [VLEN_BITS-1:0] a;
	logic [VLEN_BITS-1:0] b;
	errs = err_count;
	repeat (n) begin
		a = {$random(seed), $random(seed)};
		b = {$random(seed), $random(seed)};
		r = $random(seed);
		case (r % 32'd3)
			32'd0:   op = OP_VADD;
			32'd1:   op = OP_VSUB;
			default: op = OP_VRSUB;
		endcase
		exec_and_check(a, b, r[1:0], op);
	end
	note_result("random ops", errs);
endtask

task automatic test_backpressure();
	int                    errs;
	logic [AXI_DATA_W-1:0] held;
	logic [AXI_DATA_W-1:0] lo;
	logic [AXI_DATA_W-1:0] hi;
	errs    = err_count;
	awaddr  = REG_VEC1_LO;
	wdata   = 32'h1234_5678;
	wstrb   = '1;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	aw_accept();
	awaddr  = REG_VEC1_HI;  // second write waits behind the response
	wdata   = 32'h9abc_def0;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	repeat (6) begin
		@(negedge clk);
		if (!bvalid || bresp !== 2'b00)
			protocol_fault("write response lost while bready was low");
		if (awready || wready)
			protocol_fault("second write accepted before first response was taken");
	end
	@(posedge clk);
	#1;
	take_write_resp();
	aw_accept();
	take_write_resp();
	araddr  = REG_VEC1_LO;
	arvalid = 1'b1;
	ar_accept();
	@(negedge clk);
	held = rdata;
	repeat (5) begin
		if (!rvalid || rdata !== held)
			protocol_fault("read data changed while rready was low");
		@(negedge clk);
	end
	@(posedge clk);
	#1;
	take_read_data(lo);
	axil_read(REG_VEC1_HI, hi);
	check_data({hi, lo}, 64'h9abc_def0_1234_5678, "operand after back-pressure");
	note_result("back-pressure", errs);
endtask

/* test/tb_vadd_top.sv */
`timescale 1ns/1ps

module tb_vadd_top;
	import vec_alu_pkg::*;

	localparam int TIMEOUT_CYCLES = 60 * 40 + 1600;  // ~60 ops, each under 40 cycles

	logic                    clk;
	logic                    rst;
	logic [AXI_ADDR_W-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [AXI_DATA_W-1:0]   wdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [AXI_ADDR_W-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	logic [AXI_DATA_W-1:0]   rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;
	int                      cycles;
	int                      err_count;
	int                      tests_ok;
	int                      tests_bad;
	integer                  seed;

	vadd_top i_dut (.*);

	`include "tb_vadd_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rst       = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		cycles    = 0;
		err_count = 0;
		tests_ok  = 0;
		tests_bad = 0;
		seed      = 32'h8a33;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset_state();
		test_e8_wrap();
		test_sub_borrow();
		test_e64_ops();
		test_random_ops(40);
		test_backpressure();
		$display("%0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad, err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* source/vadd_top.sv */
`timescale 1ns/1ps

module vadd_top (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [vec_alu_pkg::AXI_ADDR_W-1:0]   awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [vec_alu_pkg::AXI_DATA_W-1:0]   wdata,
	input  logic [vec_alu_pkg::AXI_DATA_W/8-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [vec_alu_pkg::AXI_ADDR_W-1:0]   araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [vec_alu_pkg::AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready
);
	import vec_alu_pkg::*;

	logic                 op_valid;
	logic [VLEN_BITS-1:0] op_vec0;
	logic [VLEN_BITS-1:0] op_vec1;
	logic [SEW_W-1:0]     op_sew;
	logic [OPSEL_W-1:0]   op_opsel;
	logic                 res_valid;
	logic [VLEN_BITS-1:0] res_data;
	logic [FLAG_W-1:0]    res_flags;

	axil_vadd_regs i_regs (
		.clk       (clk),
		.rst       (rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.op_valid  (op_valid),
		.op_vec0   (op_vec0),
		.op_vec1   (op_vec1),
		.op_sew    (op_sew),
		.op_opsel  (op_opsel),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_flags (res_flags)
	);

	vadd_exec i_exec (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op_vec0   (op_vec0),
		.op_vec1   (op_vec1),
		.op_sew    (op_sew),
		.op_opsel  (op_opsel),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_flags (res_flags)
	);

endmodule

/* source/axil_vadd_regs.sv */
`timescale 1ns/1ps

module axil_vadd_regs (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [vec_alu_pkg::AXI_ADDR_W-1:0]   awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [vec_alu_pkg::AXI_DATA_W-1:0]   wdata,
	input  logic [vec_alu_pkg::AXI_DATA_W/8-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [vec_alu_pkg::AXI_ADDR_W-1:0]   araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [vec_alu_pkg::AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	output logic                                 op_valid,
	output logic [vec_alu_pkg::VLEN_BITS-1:0]    op_vec0,
	output logic [vec_alu_pkg::VLEN_BITS-1:0]    op_vec1,
	output logic [vec_alu_pkg::SEW_W-1:0]        op_sew,
	output logic [vec_alu_pkg::OPSEL_W-1:0]      op_opsel,
	input  logic                                 res_valid,
	input  logic [vec_alu_pkg::VLEN_BITS-1:0]    res_data,
	input  logic [vec_alu_pkg::FLAG_W-1:0]       res_flags
);
	import vec_alu_pkg::*;

	logic                  aw_rdy;
	logic                  wr_en;
	logic                  rd_en;
	logic                  start_wr;
	logic [VLEN_BITS-1:0]  vec0_q;
	logic [VLEN_BITS-1:0]  vec1_q;
	logic [VLEN_BITS-1:0]  res_q;
	logic [SEW_W-1:0]      sew_q;
	logic [OPSEL_W-1:0]    opsel_q;
	logic [FLAG_W-1:0]     flags_q;
	logic                  done_q;
	logic [AXI_DATA_W-1:0] rd_mux;

	function automatic logic [AXI_DATA_W-1:0] merge(
		input logic [AXI_DATA_W-1:0]   cur,
		input logic [AXI_DATA_W-1:0]   nxt,
		input logic [AXI_DATA_W/8-1:0] strb
	);
		logic [AXI_DATA_W-1:0] val;
		val = cur;
		for (int b = 0; b < AXI_DATA_W/8; b++) begin
			if (strb[b])
				val[8*b +: 8] = nxt[8*b +: 8];
		end
		return val;
	endfunction

	assign awready  = aw_rdy;
	assign wready   = aw_rdy;  // aw and w taken together
	assign wr_en    = aw_rdy & awvalid & wvalid;
	assign rd_en    = arready & arvalid;
	assign start_wr = wr_en && (awaddr == REG_CTRL) && wstrb[3] && wdata[CTRL_START];
	assign bresp    = 2'b00;
	assign rresp    = 2'b00;

	assign op_vec0  = vec0_q;
	assign op_vec1  = vec1_q;
	assign op_sew   = sew_q;
	assign op_opsel = opsel_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_rdy <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			aw_rdy <= ~aw_rdy & awvalid & wvalid & ~bvalid;  // one-cycle pulse
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vec0_q   <= '0;
			vec1_q   <= '0;
			sew_q    <= '0;
			opsel_q  <= '0;
			res_q    <= '0;
			flags_q  <= '0;
			done_q   <= 1'b0;
			op_valid <= 1'b0;
		end else begin
			op_valid <= start_wr;
			if (res_valid) begin
				res_q   <= res_data;
				flags_q <= res_flags;
				done_q  <= 1'b1;
			end
			if (start_wr)
				done_q <= 1'b0;  // new start wins over a late result
			if (wr_en) begin
				case (awaddr)
					REG_VEC0_LO: vec0_q[0 +: AXI_DATA_W] <=
						merge(vec0_q[0 +: AXI_DATA_W], wdata, wstrb);
					REG_VEC0_HI: vec0_q[AXI_DATA_W +: AXI_DATA_W] <=
						merge(vec0_q[AXI_DATA_W +: AXI_DATA_W], wdata, wstrb);
					REG_VEC1_LO: vec1_q[0 +: AXI_DATA_W] <=
						merge(vec1_q[0 +: AXI_DATA_W], wdata, wstrb);
					REG_VEC1_HI: vec1_q[AXI_DATA_W +: AXI_DATA_W] <=
						merge(vec1_q[AXI_DATA_W +: AXI_DATA_W], wdata, wstrb);
					REG_CTRL: begin
						if (wstrb[0]) begin
							sew_q   <= wdata[0 +: SEW_W];
							opsel_q <= wdata[SEW_W +: OPSEL_W];
						end
					end
					default: ;  // read-only or unmapped
				endcase
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (araddr)
			REG_VEC0_LO: rd_mux = vec0_q[0 +: AXI_DATA_W];
			REG_VEC0_HI: rd_mux = vec0_q[AXI_DATA_W +: AXI_DATA_W];
			REG_VEC1_LO: rd_mux = vec1_q[0 +: AXI_DATA_W];
			REG_VEC1_HI: rd_mux = vec1_q[AXI_DATA_W +: AXI_DATA_W];
			REG_CTRL: begin
				rd_mux[0 +: SEW_W]       = sew_q;
				rd_mux[SEW_W +: OPSEL_W] = opsel_q;  // start reads back as zero
			end
			REG_STATUS: begin
				rd_mux[0]                   = done_q;
				rd_mux[STAT_FLAGS +: FLAG_W] = flags_q;
			end
			REG_RES_LO:  rd_mux = res_q[0 +: AXI_DATA_W];
			REG_RES_HI:  rd_mux = res_q[AXI_DATA_W +: AXI_DATA_W];
			default:     rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
		end else begin
			arready <= ~arready & arvalid & ~rvalid;
			if (rd_en) begin
				rvalid <= 1'b1;
				rdata  <= rd_mux;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

/* source/vadd_exec.sv */
`timescale 1ns/1ps

module vadd_exec (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              op_valid,
	input  logic [vec_alu_pkg::VLEN_BITS-1:0] op_vec0,
	input  logic [vec_alu_pkg::VLEN_BITS-1:0] op_vec1,
	input  logic [vec_alu_pkg::SEW_W-1:0]     op_sew,
	input  logic [vec_alu_pkg::OPSEL_W-1:0]   op_opsel,
	output logic                              res_valid,
	output logic [vec_alu_pkg::VLEN_BITS-1:0] res_data,
	output logic [vec_alu_pkg::FLAG_W-1:0]    res_flags
);
	import vec_alu_pkg::*;

	logic [EXT_BITS-1:0]  sum_c;
	logic                 s1_valid;
	logic [EXT_BITS-1:0]  s1_sum;
	logic [SEW_W-1:0]     s1_sew;
	logic [OPSEL_W-1:0]   s1_opsel;
	logic [VLEN_BITS-1:0] pk_data;
	logic [FLAG_W-1:0]    pk_flags;

	vadd_unit_block i_unit (
		.vec0    (op_vec0),
		.vec1    (op_vec1),
		.sew     (op_sew),
		.opsel   (op_opsel),
		.ext_sum (sum_c)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= op_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_sum   <= sum_c;
		s1_sew   <= op_sew;  // packer needs the same op's sew
		s1_opsel <= op_opsel;
	end

	vadd_result_pack i_pack (
		.ext_sum (s1_sum),
		.sew     (s1_sew),
		.opsel   (s1_opsel),
		.data    (pk_data),
		.flags   (pk_flags)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		res_data  <= pk_data;
		res_flags <= pk_flags;
	end

endmodule

/* source/vadd_result_pack.sv */
`timescale 1ns/1ps

module vadd_result_pack (
	input  logic [vec_alu_pkg::EXT_BITS-1:0]  ext_sum,
	input  logic [vec_alu_pkg::SEW_W-1:0]     sew,
	input  logic [vec_alu_pkg::OPSEL_W-1:0]   opsel,
	output logic [vec_alu_pkg::VLEN_BITS-1:0] data,
	output logic [vec_alu_pkg::FLAG_W-1:0]    flags
);
	import vec_alu_pkg::*;

	logic [FLAG_W-1:0] byte_carry;
	logic [FLAG_W-1:0] elem_top;
	logic [FLAG_W-1:0] raw_flags;

	// sign slot holds 1+0+c, so its sum bit is the inverted carry in
	generate
		for (genvar i = 0; i < FLAG_W; i++) begin : g_lane
			assign data[8*i +: 8] = ext_sum[LANE_BITS*i+1 +: 8];
			assign byte_carry[i]  = ~ext_sum[LANE_BITS*i+9];
		end
	endgenerate

	always_comb begin
		case (sew)
			SEW_E8:  elem_top = 8'hff;
			SEW_E16: elem_top = 8'haa;
			SEW_E32: elem_top = 8'h88;
			default: elem_top = 8'h80;
		endcase
	end

	assign raw_flags = op_is_sub(opsel) ? ~byte_carry : byte_carry;  // borrow on sub
	assign flags     = elem_top & raw_flags;

endmodule

/* source/vadd_unit_block.sv */
`timescale 1ns/1ps

module vadd_unit_block (
	input  logic [vec_alu_pkg::VLEN_BITS-1:0] vec0,
	input  logic [vec_alu_pkg::VLEN_BITS-1:0] vec1,
	input  logic [vec_alu_pkg::SEW_W-1:0]     sew,
	input  logic [vec_alu_pkg::OPSEL_W-1:0]   opsel,
	output logic [vec_alu_pkg::EXT_BITS-1:0]  ext_sum
);
	import vec_alu_pkg::*;

	logic                  is_sub;
	logic                  inv0;
	logic                  inv1;
	logic [VLEN_BITS-1:0]  src0;
	logic [VLEN_BITS-1:0]  src1;
	logic [FLAG_W-1:0]     joined;  // guard lies inside an element
	logic [EXT_BITS-2:0]   ext0;
	logic [EXT_BITS-2:0]   ext1;

	assign is_sub = op_is_sub(opsel);
	assign inv0   = (opsel == OP_VRSUB);
	assign inv1   = (opsel == OP_VSUB);

	assign src0 = inv0 ? ~vec0 : vec0;
	assign src1 = inv1 ? ~vec1 : vec1;

	// lane 0 always opens an element
	assign joined[0] = 1'b0;
	assign joined[1] = (sew != SEW_E8);
	assign joined[2] = (sew == SEW_E32) || (sew == SEW_E64);
	assign joined[3] = (sew != SEW_E8);
	assign joined[4] = (sew == SEW_E64);
	assign joined[5] = (sew != SEW_E8);
	assign joined[6] = (sew == SEW_E32) || (sew == SEW_E64);
	assign joined[7] = (sew != SEW_E8);

	// a 1/0 guard pair passes the carry, an is_sub pair kills it or injects the +1
	generate
		for (genvar i = 0; i < FLAG_W; i++) begin : g_lane
			assign ext0[LANE_BITS*i +: LANE_BITS] = {
				1'b1,
				src0[8*i +: 8],
				joined[i] ? 1'b1 : is_sub
			};
			assign ext1[LANE_BITS*i +: LANE_BITS] = {
				1'b0,
				src1[8*i +: 8],
				joined[i] ? 1'b0 : is_sub
			};
		end
	endgenerate

	assign ext_sum = {1'b0, ext0} + {1'b0, ext1};  // single 81-bit adder

endmodule

/* source/vec_alu_pkg.sv */
package vec_alu_pkg;

	localparam int VLEN_BITS = 64;
	localparam int EXT_BITS  = 81;  // 8 lanes of 10 bits plus final carry
	localparam int LANE_BITS = 10;  // guard, 8 data bits, sign
	localparam int FLAG_W    = 8;

	localparam int SEW_W = 2;
	localparam logic [SEW_W-1:0] SEW_E8  = 2'd0;
	localparam logic [SEW_W-1:0] SEW_E16 = 2'd1;
	localparam logic [SEW_W-1:0] SEW_E32 = 2'd2;
	localparam logic [SEW_W-1:0] SEW_E64 = 2'd3;

	localparam int OPSEL_W = 6;
	localparam logic [OPSEL_W-1:0] OP_VADD  = 6'b000000;
	localparam logic [OPSEL_W-1:0] OP_VSUB  = 6'b000010;  // vec0 - vec1
	localparam logic [OPSEL_W-1:0] OP_VRSUB = 6'b000011;  // vec1 - vec0

	localparam int AXI_ADDR_W = 5;
	localparam int AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] REG_VEC0_LO = 5'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_VEC0_HI = 5'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_VEC1_LO = 5'h08;
	localparam logic [AXI_ADDR_W-1:0] REG_VEC1_HI = 5'h0c;
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 5'h10;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS  = 5'h14;
	localparam logic [AXI_ADDR_W-1:0] REG_RES_LO  = 5'h18;
	localparam logic [AXI_ADDR_W-1:0] REG_RES_HI  = 5'h1c;

	localparam int CTRL_START  = 31;
	localparam int STAT_FLAGS  = 8;  // flags field lsb in status

	function automatic logic op_is_sub(input logic [OPSEL_W-1:0] opsel);
		return (opsel == OP_VSUB) || (opsel == OP_VRSUB);
	endfunction

	function automatic logic op_is_add(input logic [OPSEL_W-1:0] opsel);
		return opsel == OP_VADD;
	endfunction

endpackage
